/* run_sim.sh */
#!/bin/sh
# Build and run the vec_coproc testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f vec_coproc.f --top-module vec_coproc_tb \
	-o vec_coproc_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/vec_coproc_sim > sim.log 2>&1
cat sim.log
grep -q "Simulation completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* vec_coproc.f */
verilog/vec_isa_pkg.sv
verilog/vec_uarch_pkg.sv
verilog/vec_stage_buf.sv
verilog/vec_regfile.sv
verilog/vec_issue.sv
verilog/vec_exec.sv
verilog/vec_coproc.sv
verif/vec_clk_gen.sv
verif/vec_coproc_assert.sv
verif/vec_coproc_tb.sv

/* verif/vec_clk_gen.sv */
module vec_clk_gen #(
	parameter int PERIOD_NS    = 40, // Clock period
	parameter int RESET_CYCLES = 4   // Cycles with reset held low
) (
	output logic clk_o,  // Free-running clock
	output logic rstn_o  // Active-low reset
);
	timeunit 1ns;
	timeprecision 1ps;

	initial clk_o = 1'b0;
	always #(PERIOD_NS / 2) clk_o = ~clk_o; // Half period toggle

	initial begin
		rstn_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		rstn_o = 1'b1; // Released away from the active edge
	end

endmodule

/* verif/vec_coproc_assert.sv */
module vec_coproc_assert import vec_uarch_pkg::*; (
	input logic            clk_i,   // DUT clock
	input logic            rstn_i,  // DUT reset
	input logic            valid_i, // Upstream valid
	input logic            pop_i,   // DUT pop_o
	input logic            done_i,  // DUT valid_o
	input vec_ctrl_state_e state_i  // Controller state
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_cnt = 0; // Assertion failures so far

	//////////////////////////////
	// Handshake with the queue
	//////////////////////////////
	property p_pop_legal;
		@(posedge clk_i) disable iff (!rstn_i)
		pop_i |-> (valid_i && state_i == S_IDLE);
	endproperty

	property p_single_flight;
		@(posedge clk_i) disable iff (!rstn_i)
		pop_i |=> !pop_i [*6]; // Busy until completion
	endproperty

	//////////////////////////////
	// Completion strobe
	//////////////////////////////
	property p_done_latency;
		@(posedge clk_i) disable iff (!rstn_i)
		pop_i |=> !done_i [*5] ##1 done_i ##1 !done_i; // Fixed 6 cycles, one-cycle pulse
	endproperty

	property p_quiet_in_reset;
		@(posedge clk_i)
		!rstn_i |-> (!pop_i && !done_i);
	endproperty

	a_pop_legal: assert property (p_pop_legal) else begin
		$error("pop_o without valid_i or outside S_IDLE");
		fail_cnt++;
	end
	a_single_flight: assert property (p_single_flight) else begin
		$error("second pop_o before completion");
		fail_cnt++;
	end
	a_done_latency: assert property (p_done_latency) else begin
		$error("valid_o not a single pulse 6 cycles after pop_o");
		fail_cnt++;
	end
	a_quiet_in_reset: assert property (p_quiet_in_reset) else begin
		$error("pop_o or valid_o high during reset");
		fail_cnt++;
	end

endmodule

/* verif/vec_coproc_tb.sv */
module vec_coproc_tb import vec_isa_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int VREGS  = 8;
	localparam int LANES  = 4;
	localparam int DATA_W = 32;
	localparam int N_INSTR = 104;              // Instructions over all tests
	localparam int LIMIT   = N_INSTR * 10 + 4; // Cycles per instruction plus reset

	logic              clk;
	logic              rstn;
	logic              valid_i;
	logic              pop_o;
	vec_op_e           opcode_i;
	logic [2:0]        vd_i;
	logic [2:0]        vs1_i;
	logic [2:0]        vs2_i;
	logic [DATA_W-1:0] rs1_i;
	logic [DATA_W-1:0] rs2_i;
	logic              reconfig_i;
	logic [DATA_W-1:0] vl_i;
	logic              valid_o;
	logic [DATA_W-1:0] result_o;
	logic              idle_o;

	logic [DATA_W-1:0] mrf [VREGS][LANES]; // Model register file
	int                mvl;                // Model vl
	int                errors;
	int                test_errs;
	int                n_pass;
	int                n_fail;
	int                cycles;
	int                assert_seen;        // Assertion failures already counted

	vec_clk_gen #(.PERIOD_NS(40), .RESET_CYCLES(4)) u_vec_clk_gen (.clk_o(clk), .rstn_o(rstn));

	vec_coproc #(.VREGS(VREGS), .LANES(LANES), .DATA_W(DATA_W)) u_vec_coproc (
		.clk_i(clk), .rstn_i(rstn), .valid_i(valid_i), .pop_o(pop_o), .opcode_i(opcode_i),
		.vd_i(vd_i), .vs1_i(vs1_i), .vs2_i(vs2_i), .rs1_i(rs1_i), .rs2_i(rs2_i),
		.reconfig_i(reconfig_i), .vl_i(vl_i), .valid_o(valid_o), .result_o(result_o),
		.idle_o(idle_o)
	);

	bind vec_coproc vec_coproc_assert u_vec_coproc_assert (
		.clk_i(clk_i), .rstn_i(rstn_i), .valid_i(valid_i), .pop_i(pop_o),
		.done_i(valid_o), .state_i(state_q)
	);

	// Run length guard
	always @(posedge clk) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("Run stopped: no completion within %0d cycles", LIMIT);
			$display("Simulation failed");
			$finish;
		end
	end

	//////////////////////////////
	// Reference model
	//////////////////////////////
	function automatic logic [DATA_W-1:0] model_result(vec_op_e op, int vs1, logic [DATA_W-1:0] rs2);
		logic [DATA_W-1:0] sum;
		sum = '0;
		if (op == VREDSUM_VS) begin
			for (int l = 0; l < mvl; l++) sum += mrf[vs1][l]; // Active lanes only
		end else if (op == VMV_XS) begin
			sum = mrf[vs1][rs2 % LANES];
		end
		return sum;
	endfunction

	task automatic model_write(vec_op_e op, int vd, int vs1, int vs2, logic [DATA_W-1:0] rs1);
		logic [DATA_W-1:0] nv [LANES];
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		for (int l = 0; l < LANES; l++) begin
			a = mrf[vs1][l];
			b = mrf[vs2][l];
			case (op)
				VMV_VX:  nv[l] = rs1;
				VADD_VV: nv[l] = a + b;
				VSUB_VV: nv[l] = a - b;
				VAND_VV: nv[l] = a & b;
				VOR_VV:  nv[l] = a | b;
				VXOR_VV: nv[l] = a ^ b;
				VADD_VX: nv[l] = a + rs1;
				default: nv[l] = mrf[vd][l];
			endcase
		end
		for (int l = 0; l < mvl; l++) mrf[vd][l] = nv[l]; // Tail untouched
	endtask

	function automatic void check_value(logic [DATA_W-1:0] got, logic [DATA_W-1:0] exp,
			string what);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s result_o %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endfunction

	//////////////////////////////
	// Stimulus
	//////////////////////////////
	task automatic run_op(vec_op_e op, int vd, int vs1, int vs2, logic [DATA_W-1:0] rs1,
			logic [DATA_W-1:0] rs2, bit reconfig, logic [DATA_W-1:0] vlreq, bit keep);
		logic [DATA_W-1:0] exp;
		int                lat;
		@(negedge clk);
		opcode_i   = op;
		vd_i       = 3'(vd);
		vs1_i      = 3'(vs1);
		vs2_i      = 3'(vs2);
		rs1_i      = rs1;
		rs2_i      = rs2;
		reconfig_i = reconfig;
		vl_i       = vlreq;
		valid_i    = 1'b1;
		if (reconfig) mvl = (vlreq > LANES) ? LANES : int'(vlreq); // Clamp to LANES
		exp = model_result(op, vs1, rs2);
		model_write(op, vd, vs1, vs2, rs1);
		do @(posedge clk); while (!pop_o);
		@(negedge clk);
		if (!keep) valid_i = 1'b0; // Held high for back-to-back
		lat = 0;
		do begin
			@(posedge clk);
			lat++;
		end while (!valid_o);
		if (lat != 6) begin
			$display("Completion came %0d cycles after pop instead of 6 (op %s)", lat, op.name());
			errors++;
		end
		check_value(result_o, exp, op.name());
	endtask

	task automatic finish_test(string name);
		int fired;
		fired       = u_vec_coproc.u_vec_coproc_assert.fail_cnt - assert_seen;
		assert_seen = u_vec_coproc.u_vec_coproc_assert.fail_cnt;
		errors += fired; // Bound assertion failures count against this test
		if (errors == test_errs) begin
			n_pass++;
			$display("Test %s: PASS", name);
		end else begin
			n_fail++;
			$display("Test %s: FAIL (%0d errors)", name, errors - test_errs);
		end
		test_errs = errors;
	endtask

	initial begin
		vec_op_e ops [6];
		vec_op_e mix [4];
		int      a;
		int      b;
		valid_i     = 1'b1; // Queue already presenting while in reset
		opcode_i    = VMV_VX;
		vd_i        = '0;
		vs1_i       = '0;
		vs2_i       = '0;
		rs1_i       = '0;
		rs2_i       = '0;
		reconfig_i  = 1'b0;
		vl_i        = '0;
		errors      = 0;
		test_errs   = 0;
		n_pass      = 0;
		n_fail      = 0;
		cycles      = 0;
		assert_seen = 0;
		mvl = LANES;
		void'($urandom(85));
		for (int r = 0; r < VREGS; r++)
			for (int l = 0; l < LANES; l++) mrf[r][l] = '0;
		ops = '{VADD_VV, VSUB_VV, VAND_VV, VOR_VV, VXOR_VV, VADD_VX};
		mix = '{VMV_VX, VADD_VX, VREDSUM_VS, VMV_XS};

		// Reset state
		repeat (2) @(negedge clk);
		valid_i = 1'b0; // Withdrawn before reset release
		@(posedge rstn);
		@(negedge clk);
		if (pop_o !== 1'b0 || valid_o !== 1'b0 || idle_o !== 1'b1) begin
			$display("** Error at %0t ns: after reset pop %b valid %b idle %b, expected 0 0 1",
				$time, pop_o, valid_o, idle_o);
			errors++;
		end
		for (int r = 0; r < VREGS; r++) run_op(VREDSUM_VS, 0, r, 0, 0, 0, 0, 0, 0);
		finish_test("reset");

		// Splat then read every element back
		for (int r = 0; r < VREGS; r++) run_op(VMV_VX, r, 0, 0, $urandom, 0, 0, 0, 0);
		for (int r = 0; r < VREGS; r++)
			for (int i = 0; i < LANES; i++)
				run_op(VMV_XS, 0, r, 0, 0, i + LANES * (r % 2), 0, 0, 0); // Index wraps
		finish_test("splat_readback");

		// Lane-wise ops
		for (int k = 0; k < 6; k++) begin
			a = $urandom_range(VREGS - 1);
			b = $urandom_range(VREGS - 1);
			run_op(ops[k], 3, a, b, $urandom, 0, 0, 0, 0);
			for (int i = 0; i < LANES; i++) run_op(VMV_XS, 0, 3, 0, 0, i, 0, 0, 0);
			run_op(VREDSUM_VS, 0, 3, 0, 0, 0, 0, 0, 0);
		end
		finish_test("lane_ops");

		// vl masking and clamp
		run_op(VMV_VX, 4, 0, 0, $urandom, 0, 1, 2, 0);
		run_op(VADD_VV, 5, 4, 1, 0, 0, 0, 0, 0);
		run_op(VREDSUM_VS, 0, 5, 0, 0, 0, 0, 0, 0);
		for (int i = 0; i < LANES; i++) run_op(VMV_XS, 0, 4, 0, 0, i, 0, 0, 0);
		run_op(VREDSUM_VS, 0, 5, 0, 0, 0, 1, 9, 0); // Clamped back to LANES
		for (int i = 0; i < LANES; i++) run_op(VMV_XS, 0, 5, 0, 0, i, 0, 0, 0);
		finish_test("vl_mask");

		// Back-to-back with valid held
		for (int k = 0; k < 8; k++)
			run_op(mix[k % 4], 6, $urandom_range(VREGS - 1), 0, $urandom, $urandom, 0, 0, k < 7);
		repeat (2) @(negedge clk); // Past the cycle after the last strobe
		if (idle_o !== 1'b1) begin
			$display("** Error at %0t ns: idle_o %b after the last completion, expected 1",
				$time, idle_o);
			errors++;
		end
		finish_test("held_valid");

		$display("Tests passed: %0d, failed: %0d", n_pass, n_fail);
		if (n_fail == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* verilog/vec_coproc.sv */
module vec_coproc import vec_isa_pkg::*, vec_uarch_pkg::*; #(
	parameter int VREGS  = 8,  // Vector registers
	parameter int LANES  = 4,  // SIMD lanes
	parameter int DATA_W = 32, // Element width
	localparam int RW    = $clog2(VREGS),
	localparam int VL_W  = vec_vl_width(LANES),
	localparam int PKT_W = vec_pkt_width($bits(vec_op_e), VREGS, LANES, DATA_W)
) (
	input  logic              clk_i,      // Clock
	input  logic              rstn_i,     // Async reset, active low
	// Upstream instruction queue
	input  logic              valid_i,    // Instruction present
	output logic              pop_o,      // Instruction taken
	input  vec_op_e           opcode_i,
	input  logic [RW-1:0]     vd_i,
	input  logic [RW-1:0]     vs1_i,
	input  logic [RW-1:0]     vs2_i,
	input  logic [DATA_W-1:0] rs1_i,      // Scalar source
	input  logic [DATA_W-1:0] rs2_i,      // Element index for VMV_XS
	input  logic              reconfig_i, // Load vl with this instruction
	input  logic [DATA_W-1:0] vl_i,       // Requested vl
	// Completion
	output logic              valid_o,    // One-cycle done strobe
	output logic [DATA_W-1:0] result_o,   // Scalar result
	output logic              idle_o      // Whole unit empty
);

	vec_ctrl_state_e              state_q;
	logic                         issue_q;  // Issue strobe, high in S_PUSH
	logic [VL_W-1:0]              vl_q;
	logic [VL_W-1:0]              vl_clamp;
	logic [DATA_W-1:0]            result_q;
	vec_op_e                      op_q;
	logic [RW-1:0]                vd_q;
	logic [RW-1:0]                vs1_q;
	logic [RW-1:0]                vs2_q;
	logic [DATA_W-1:0]            rs1_q;
	logic [DATA_W-1:0]            rs2_q;
	logic [RW-1:0]                rf_ra;
	logic [RW-1:0]                rf_rb;
	logic [LANES-1:0][DATA_W-1:0] rf_rdata_a;
	logic [LANES-1:0][DATA_W-1:0] rf_rdata_b;
	logic [LANES-1:0]             wr_en;
	logic [RW-1:0]                wr_addr;
	logic [LANES-1:0][DATA_W-1:0] wr_data;
	logic                         iss_valid;
	logic                         iss_busy;
	logic [PKT_W-1:0]             iss_pkt;
	logic                         buf_free;
	logic                         buf_avail;
	logic [PKT_W-1:0]             buf_pkt;
	logic                         ex_ready;
	logic                         ex_finished;
	logic                         ex_busy;
	logic [DATA_W-1:0]            ex_scalar;

	//////////////////////////////
	// Controller FSM
	//////////////////////////////
	assign pop_o    = rstn_i & (state_q == S_IDLE) & valid_i; // One in flight, none in reset
	assign vl_clamp = (vl_i > DATA_W'(LANES)) ? VL_W'(LANES) : vl_i[VL_W-1:0];

	always_ff @(posedge clk_i or negedge rstn_i) begin : ctrl_fsm
		if (!rstn_i) begin
			state_q  <= S_IDLE;
			issue_q  <= 1'b0;
			vl_q     <= VL_W'(LANES); // Full length out of reset
			result_q <= '0;
		end else begin
			case (state_q)
				S_IDLE: begin
					if (valid_i) begin
						issue_q <= 1'b1;
						state_q <= S_PUSH;
						if (reconfig_i) begin
							vl_q <= vl_clamp; // Auto reconfigure
						end
					end
				end
				S_PUSH: begin
					issue_q <= 1'b0;
					if (iss_busy) begin
						state_q <= S_BUSY; // Issue stage has it
					end
				end
				S_BUSY: begin
					if (ex_finished) begin
						result_q <= ex_scalar;
						state_q  <= S_DONE;
					end
				end
				S_DONE:  state_q <= S_IDLE;
				default: state_q <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin : instr_reg
		if (pop_o) begin
			op_q  <= opcode_i;
			vd_q  <= vd_i;
			vs1_q <= vs1_i;
			vs2_q <= vs2_i;
			rs1_q <= rs1_i;
			rs2_q <= rs2_i;
		end
	end

	assign valid_o  = (state_q == S_DONE);
	assign result_o = result_q;
	assign idle_o   = (state_q == S_IDLE) & ~iss_busy & ~buf_avail & ~ex_busy;

	//////////////////////////////
	// Datapath
	//////////////////////////////
	vec_regfile #(.VREGS(VREGS), .LANES(LANES), .DATA_W(DATA_W)) u_vec_regfile (
		.clk_i     (clk_i),
		.rstn_i    (rstn_i),
		.ra_i      (rf_ra),
		.rdata_a_o (rf_rdata_a),
		.rb_i      (rf_rb),
		.rdata_b_o (rf_rdata_b),
		.we_i      (wr_en),      // Writeback from execute stage 2
		.wa_i      (wr_addr),
		.wdata_i   (wr_data)
	);

	vec_issue #(.VREGS(VREGS), .LANES(LANES), .DATA_W(DATA_W)) u_vec_issue (
		.clk_i        (clk_i),
		.rstn_i       (rstn_i),
		.issue_i      (issue_q),
		.op_i         (op_q),
		.vd_i         (vd_q),
		.vs1_i        (vs1_q),
		.vs2_i        (vs2_q),
		.rs1_i        (rs1_q),
		.rs2_i        (rs2_q),
		.vl_i         (vl_q),
		.rf_ra_o      (rf_ra),
		.rf_rdata_a_i (rf_rdata_a),
		.rf_rb_o      (rf_rb),
		.rf_rdata_b_i (rf_rdata_b),
		.valid_o      (iss_valid),
		.pkt_o        (iss_pkt),
		.ready_i      (buf_free),
		.busy_o       (iss_busy)
	);

	vec_stage_buf #(.WIDTH(PKT_W)) u_is_ex_buf (
		.clk_i   (clk_i),
		.rstn_i  (rstn_i),
		.wdata_i (iss_pkt),
		.we_i    (iss_valid),
		.free_o  (buf_free),
		.rdata_o (buf_pkt),
		.avail_o (buf_avail),
		.re_i    (ex_ready)
	);

	vec_exec #(.VREGS(VREGS), .LANES(LANES), .DATA_W(DATA_W)) u_vec_exec (
		.clk_i      (clk_i),
		.rstn_i     (rstn_i),
		.valid_i    (buf_avail),
		.pkt_i      (buf_pkt),
		.ready_o    (ex_ready),
		.wr_en_o    (wr_en),
		.wr_addr_o  (wr_addr),
		.wr_data_o  (wr_data),
		.finished_o (ex_finished),
		.scalar_o   (ex_scalar),
		.busy_o     (ex_busy)
	);

endmodule

/* verilog/vec_exec.sv */
module vec_exec import vec_isa_pkg::*, vec_uarch_pkg::*; #(
	parameter int VREGS  = 8,
	parameter int LANES  = 4,  // Power of two for the reduction tree
	parameter int DATA_W = 32,
	localparam int RW    = $clog2(VREGS),
	localparam int VL_W  = vec_vl_width(LANES),
	localparam int IDX_W = $clog2(LANES),
	localparam int LVLS  = $clog2(LANES),
	localparam int PKT_W = vec_pkt_width($bits(vec_op_e), VREGS, LANES, DATA_W)
) (
	input  logic                          clk_i,
	input  logic                          rstn_i,
	// From stage buffer
	input  logic                          valid_i,
	input  logic [PKT_W-1:0]              pkt_i,
	output logic                          ready_o,
	// Writeback
	output logic [LANES-1:0]              wr_en_o,    // Per-lane enable
	output logic [RW-1:0]                 wr_addr_o,
	output logic [LANES-1:0][DATA_W-1:0]  wr_data_o,
	// Status
	output logic                          finished_o, // Instruction complete
	output logic [DATA_W-1:0]             scalar_o,   // Held scalar result
	output logic                          busy_o
);

	logic [$bits(vec_op_e)-1:0]          in_op_bits;
	logic [$bits(vec_result_kind_e)-1:0] in_kind_bits;
	vec_op_e                             in_op;
	vec_result_kind_e                    in_kind;
	logic [RW-1:0]                       in_vd;
	logic [VL_W-1:0]                     in_vl;
	logic [IDX_W-1:0]                    in_idx;
	logic [LANES-1:0][DATA_W-1:0]        in_a;
	logic [LANES-1:0][DATA_W-1:0]        in_b;
	logic [LANES-1:0][DATA_W-1:0]        lane_res;
	logic [LANES-1:0]                    lane_we;
	logic [LVLS:0][LANES-1:0][DATA_W-1:0] red_lvl;
	logic [DATA_W-1:0]                   scalar_res;
	logic                                accept;
	logic                                s1_valid_q;
	logic [LANES-1:0][DATA_W-1:0]        s1_res_q;
	logic [LANES-1:0]                    s1_we_q;
	logic [RW-1:0]                       s1_vd_q;
	logic [DATA_W-1:0]                   s1_scalar_q;

	assign {in_op_bits, in_kind_bits, in_vd, in_vl, in_idx, in_a, in_b} = pkt_i;
	assign in_op   = vec_op_e'(in_op_bits);
	assign in_kind = vec_result_kind_e'(in_kind_bits);
	assign ready_o = 1'b1; // Never stalls
	assign accept  = valid_i & ready_o;

	//////////////////////////////
	// Stage 1 lane ALU
	//////////////////////////////
	always_comb begin : lane_alu
		for (int l = 0; l < LANES; l++) begin
			case (in_op)
				VMV_VX:           lane_res[l] = in_b[l]; // Splatted scalar
				VADD_VV, VADD_VX: lane_res[l] = in_a[l] + in_b[l];
				VSUB_VV:          lane_res[l] = in_a[l] - in_b[l];
				VAND_VV:          lane_res[l] = in_a[l] & in_b[l];
				VOR_VV:           lane_res[l] = in_a[l] | in_b[l];
				VXOR_VV:          lane_res[l] = in_a[l] ^ in_b[l];
				default:          lane_res[l] = in_a[l]; // Scalar ops write nothing
			endcase
			lane_we[l] = (in_kind == RES_VECTOR) && (l < int'(in_vl)); // Tail undisturbed
		end
	end

	// Masked sum over active lanes, wraps at DATA_W
	always_comb begin : red_tree
		red_lvl = '0;
		for (int l = 0; l < LANES; l++) begin
			if (l < int'(in_vl)) begin
				red_lvl[0][l] = in_a[l];
			end
		end
		for (int k = 0; k < LVLS; k++) begin
			for (int i = 0; i < (LANES >> (k + 1)); i++) begin
				red_lvl[k + 1][i] = red_lvl[k][2 * i] + red_lvl[k][2 * i + 1]; // Pairwise add
			end
		end
	end

	always_comb begin : scalar_sel
		scalar_res = '0; // Vector ops return zero
		if (in_kind == RES_SCALAR) begin
			scalar_res = (in_op == VREDSUM_VS) ? red_lvl[LVLS][0] : in_a[in_idx];
		end
	end

	//////////////////////////////
	// Stage 2 writeback
	//////////////////////////////
	always_ff @(posedge clk_i or negedge rstn_i) begin : s1_ctrl
		if (!rstn_i) begin
			s1_valid_q  <= 1'b0;
			s1_scalar_q <= '0;
		end else begin
			s1_valid_q <= accept; // One-cycle finish pulse
			if (accept) begin
				s1_scalar_q <= scalar_res; // Held until next instruction
			end
		end
	end

	always_ff @(posedge clk_i) begin : s1_data
		if (accept) begin
			s1_res_q <= lane_res;
			s1_we_q  <= lane_we;
			s1_vd_q  <= in_vd;
		end
	end

	assign wr_en_o    = s1_we_q & {LANES{s1_valid_q}};
	assign wr_addr_o  = s1_vd_q;
	assign wr_data_o  = s1_res_q;
	assign finished_o = s1_valid_q;
	assign scalar_o   = s1_scalar_q;
	assign busy_o     = s1_valid_q;

endmodule

/* verilog/vec_isa_pkg.sv */
package vec_isa_pkg;

	//////////////////////////////
	// Vector operations
	//////////////////////////////
	typedef enum logic [3:0] {
		VMV_VX     = 4'd0, // Splat scalar into vd
		VADD_VV    = 4'd1, // vd = vs1 + vs2
		VSUB_VV    = 4'd2, // vd = vs1 - vs2
		VAND_VV    = 4'd3, // vd = vs1 & vs2
		VOR_VV     = 4'd4, // vd = vs1 | vs2
		VXOR_VV    = 4'd5, // vd = vs1 ^ vs2
		VADD_VX    = 4'd6, // vd = vs1 + scalar
		VREDSUM_VS = 4'd7, // Sum of active lanes to scalar
		VMV_XS     = 4'd8  // Element rs2 of vs1 to scalar
	} vec_op_e;

	//////////////////////////////
	// Second operand source
	//////////////////////////////
	typedef enum logic {
		OPND_VEC    = 1'b0, // Operand B from vs2
		OPND_SCALAR = 1'b1  // Operand B is rs1 splat over all lanes
	} vec_opnd_e;

	// Operand B source per operation
	function automatic vec_opnd_e vec_op_opnd(vec_op_e op);
		vec_opnd_e sel;
		sel = OPND_VEC;
		if (op == VMV_VX || op == VADD_VX) begin
			sel = OPND_SCALAR; // Scalar forms
		end
		return sel;
	endfunction

endpackage

/* verilog/vec_issue.sv */
module vec_issue import vec_isa_pkg::*, vec_uarch_pkg::*; #(
	parameter int VREGS  = 8,
	parameter int LANES  = 4,
	parameter int DATA_W = 32,
	localparam int RW    = $clog2(VREGS),
	localparam int VL_W  = vec_vl_width(LANES),
	localparam int IDX_W = $clog2(LANES),
	localparam int PKT_W = vec_pkt_width($bits(vec_op_e), VREGS, LANES, DATA_W)
) (
	input  logic                          clk_i,
	input  logic                          rstn_i,
	// From controller
	input  logic                          issue_i,      // One-cycle issue strobe
	input  vec_op_e                       op_i,
	input  logic [RW-1:0]                 vd_i,
	input  logic [RW-1:0]                 vs1_i,
	input  logic [RW-1:0]                 vs2_i,
	input  logic [DATA_W-1:0]             rs1_i,        // Scalar operand
	input  logic [DATA_W-1:0]             rs2_i,        // Element index source
	input  logic [VL_W-1:0]               vl_i,         // Current vl
	// Register file
	output logic [RW-1:0]                 rf_ra_o,
	input  logic [LANES-1:0][DATA_W-1:0]  rf_rdata_a_i,
	output logic [RW-1:0]                 rf_rb_o,
	input  logic [LANES-1:0][DATA_W-1:0]  rf_rdata_b_i,
	// To stage buffer
	output logic                          valid_o,
	output logic [PKT_W-1:0]              pkt_o,
	input  logic                          ready_i,
	output logic                          busy_o        // Stage holds an instruction
);

	logic                         rd_pend_q; // Read phase pending
	logic                         valid_q;   // Packet waiting for buffer
	vec_op_e                      op_q;
	logic [RW-1:0]                vd_q;
	logic [RW-1:0]                ra_q;
	logic [RW-1:0]                rb_q;
	logic [DATA_W-1:0]            scalar_q;
	logic [IDX_W-1:0]             idx_q;
	logic [VL_W-1:0]              vl_q;
	logic [PKT_W-1:0]             pkt_q;
	vec_opnd_e                    opnd;
	vec_result_kind_e             kind;
	logic [LANES-1:0][DATA_W-1:0] opb;

	//////////////////////////////
	// Address phase
	//////////////////////////////
	always_ff @(posedge clk_i) begin : fields
		if (issue_i) begin
			op_q     <= op_i;
			vd_q     <= vd_i;
			ra_q     <= vs1_i;
			rb_q     <= vs2_i;
			scalar_q <= rs1_i;
			idx_q    <= rs2_i[IDX_W-1:0]; // Index modulo LANES
			vl_q     <= vl_i;
		end
	end

	assign rf_ra_o = ra_q; // Registered read addresses
	assign rf_rb_o = rb_q;

	//////////////////////////////
	// Operand phase
	//////////////////////////////
	always_comb begin : operand_sel
		opnd = vec_op_opnd(op_q);
		kind = (op_q == VREDSUM_VS || op_q == VMV_XS) ? RES_SCALAR : RES_VECTOR;
		if (opnd == OPND_SCALAR) begin
			opb = {LANES{scalar_q}}; // Splat rs1
		end else begin
			opb = rf_rdata_b_i;
		end
	end

	always_ff @(posedge clk_i) begin : pkt_reg
		if (rd_pend_q) begin
			pkt_q <= {op_q, kind, vd_q, vl_q, idx_q, rf_rdata_a_i, opb};
		end
	end

	always_ff @(posedge clk_i or negedge rstn_i) begin : stage_ctrl
		if (!rstn_i) begin
			rd_pend_q <= 1'b0;
			valid_q   <= 1'b0;
		end else begin
			rd_pend_q <= issue_i;
			if (rd_pend_q) begin
				valid_q <= 1'b1; // Packet ready next cycle
			end else if (valid_q && ready_i) begin
				valid_q <= 1'b0; // Taken by buffer
			end
		end
	end

	assign valid_o = valid_q;
	assign pkt_o   = pkt_q;
	assign busy_o  = rd_pend_q | valid_q;

endmodule

/* verilog/vec_regfile.sv */
module vec_regfile #(
	parameter int VREGS  = 8,  // Architectural vector registers
	parameter int LANES  = 4,  // Elements per register
	parameter int DATA_W = 32, // Element width
	localparam int RW    = $clog2(VREGS)
) (
	input  logic                          clk_i,     // Clock
	input  logic                          rstn_i,    // Async reset, active low
	// Read port A
	input  logic [RW-1:0]                 ra_i,      // Register index
	output logic [LANES-1:0][DATA_W-1:0]  rdata_a_o, // Whole vector
	// Read port B
	input  logic [RW-1:0]                 rb_i,
	output logic [LANES-1:0][DATA_W-1:0]  rdata_b_o,
	// Write port
	input  logic [LANES-1:0]              we_i,      // Per-lane enable
	input  logic [RW-1:0]                 wa_i,      // Destination register
	input  logic [LANES-1:0][DATA_W-1:0]  wdata_i    // Lane data
);

	//////////////////////////////
	// Storage
	//////////////////////////////
	logic [LANES-1:0][DATA_W-1:0] regs_q [VREGS]; // VREGS x LANES elements

	always_ff @(posedge clk_i or negedge rstn_i) begin : rf_write
		if (!rstn_i) begin
			for (int r = 0; r < VREGS; r++) begin
				regs_q[r] <= '0; // All registers start at zero
			end
		end else begin
			for (int l = 0; l < LANES; l++) begin
				if (we_i[l]) begin
					regs_q[wa_i][l] <= wdata_i[l]; // Disabled lanes keep old value
				end
			end
		end
	end

	//////////////////////////////
	// Read ports
	//////////////////////////////
	assign rdata_a_o = regs_q[ra_i]; // Combinational
	assign rdata_b_o = regs_q[rb_i];

endmodule

/* verilog/vec_stage_buf.sv */
module vec_stage_buf #(
	parameter int WIDTH = 32 // Payload width
) (
	input  logic             clk_i,   // Clock
	input  logic             rstn_i,  // Async reset, active low
	// Write side
	input  logic [WIDTH-1:0] wdata_i, // Word from producer
	input  logic             we_i,    // Producer valid
	output logic             free_o,  // Slot empty, producer may write
	// Read side
	output logic [WIDTH-1:0] rdata_o, // Stored word
	output logic             avail_o, // Slot full
	input  logic             re_i     // Consumer ready
);

	logic             full_q; // Occupancy
	logic [WIDTH-1:0] data_q; // Stored payload
	logic             wr_en;
	logic             rd_en;

	assign wr_en = we_i & ~full_q; // Only when empty
	assign rd_en = re_i & full_q;

	always_ff @(posedge clk_i or negedge rstn_i) begin : occ_flag
		if (!rstn_i) begin
			full_q <= 1'b0;
		end else if (rd_en) begin
			full_q <= 1'b0; // Word consumed
		end else if (wr_en) begin
			full_q <= 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin : payload
		if (wr_en) begin
			data_q <= wdata_i;
		end
	end

	assign free_o  = ~full_q;
	assign avail_o = full_q;
	assign rdata_o = data_q; // Read is combinational from the slot

endmodule

/* verilog/vec_uarch_pkg.sv */
package vec_uarch_pkg;

	// Controller FSM states
	typedef enum logic [1:0] {
		S_IDLE = 2'd0, // Waiting for an instruction
		S_PUSH = 2'd1, // Instruction handed to issue
		S_BUSY = 2'd2, // Waiting for execute to finish
		S_DONE = 2'd3  // Completion strobe
	} vec_ctrl_state_e;

	// Where the execute stage puts its result
	typedef enum logic {
		RES_VECTOR = 1'b0, // Written back to vd
		RES_SCALAR = 1'b1  // Returned on result_o
	} vec_result_kind_e;

	// vl needs to hold 0..LANES
	function automatic int vec_vl_width(int lanes);
		return $clog2(lanes) + 1;
	endfunction

	// Issue to execute packet width {op, kind, vd, vl, idx, opa, opb}
	function automatic int vec_pkt_width(int op_w, int vregs, int lanes, int data_w);
		return op_w + $bits(vec_result_kind_e) + $clog2(vregs) + vec_vl_width(lanes) +
			$clog2(lanes) + 2 * lanes * data_w;
	endfunction

endpackage
